// File: source/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // RV32I datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the execute slice
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct7 that selects SUB and SRA
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Decode to execute payload
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd_addr;
    } id_ex_t;

    // Execute to memory payload
    // result doubles as the address for loads and stores
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  illegal;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: source/pipe_stage_reg.sv
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Valid follows the strobe every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // Payload only moves on a real instruction, bubbles leave it alone
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= '0;
        end else if (valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    valid_known_a: assert property (
        @(posedge clk) disable iff (!arst_n_i) !$isunknown(valid_o)
    );

endmodule

`default_nettype wire

// File: source/operand_select.sv
`default_nettype none

module operand_select (
    input  logic [exu_pkg::XLEN-1:0] inst_i,
    input  logic [exu_pkg::XLEN-1:0] pc_i,
    input  logic [exu_pkg::XLEN-1:0] rs1_data_i,
    input  logic [exu_pkg::XLEN-1:0] rs2_data_i,
    output logic [exu_pkg::XLEN-1:0] op_a_o,
    output logic [exu_pkg::XLEN-1:0] op_b_o
);

    import exu_pkg::*;

    logic [6:0]      opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;

    assign opcode = inst_i[6:0];

    // Sign-extended 12-bit immediates
    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // Upper 20 bits, low 12 zero
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OPC_AUIPC: begin
                op_a_o = pc_i;
            end
            OPC_LUI: begin
                op_a_o = '0;
            end
            default: begin
                op_a_o = rs1_data_i;
            end
        endcase
    end

    // Shift-immediates pass the whole I immediate, ALU only looks at shamt
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                op_b_o = imm_u;
            end
            OPC_STORE: begin
                op_b_o = imm_s;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                op_b_o = imm_i;
            end
            OPC_OP: begin
                op_b_o = rs2_data_i;
            end
            default: begin
                op_b_o = rs2_data_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu_op_decoder.sv
`default_nettype none

module alu_op_decoder (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [exu_pkg::XLEN-1:0]  inst_i,
    output exu_pkg::alu_op_e          alu_op_o,
    output logic                      illegal_o
);

    import exu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        alu_op_o  = ALU_ADD;
        illegal_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                alu_op_o = ALU_PASS_B;
            end
            // Address and PC-relative forms all add
            OPC_AUIPC, OPC_LOAD, OPC_STORE: begin
                alu_op_o = ALU_ADD;
            end
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000: begin
                        // Bits 31:25 of an ADDI are immediate, never SUB
                        if (opcode == OPC_OP && funct7 == FUNCT7_ALT) begin
                            alu_op_o = ALU_SUB;
                        end else begin
                            alu_op_o = ALU_ADD;
                        end
                    end
                    3'b001: alu_op_o = ALU_SLL;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b101: begin
                        if (funct7 == FUNCT7_ALT) begin
                            alu_op_o = ALU_SRA;
                        end else begin
                            alu_op_o = ALU_SRL;
                        end
                    end
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: alu_op_o = ALU_ADD;
                endcase
            end
            default: begin
                alu_op_o  = ALU_ADD;
                illegal_o = 1'b1;
            end
        endcase
    end

    alu_op_member_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(alu_op_o) && (alu_op_o inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
            ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B})
    );

endmodule

`default_nettype wire

// File: source/int_alu.sv
`default_nettype none

module int_alu (
    input  logic [exu_pkg::XLEN-1:0] op_a_i,
    input  logic [exu_pkg::XLEN-1:0] op_b_i,
    input  exu_pkg::alu_op_e         alu_op_i,
    output logic [exu_pkg::XLEN-1:0] result_o
);

    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // RV32I shifts only honour the low five bits
    assign shamt = op_b_i[4:0];

    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                result_o = op_a_i + op_b_i;
            end
            ALU_SUB: begin
                result_o = op_a_i - op_b_i;
            end
            ALU_SLL: begin
                result_o = op_a_i << shamt;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            ALU_SRL: begin
                result_o = op_a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(op_a_i) >>> shamt);
            end
            ALU_OR: begin
                result_o = op_a_i | op_b_i;
            end
            ALU_AND: begin
                result_o = op_a_i & op_b_i;
            end
            ALU_PASS_B: begin
                result_o = op_b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`default_nettype none

module exec_unit (
    input  logic                             clk,
    input  logic                             arst_n_i,
    // From decode
    input  logic                             valid_i,
    input  logic [exu_pkg::XLEN-1:0]         inst_i,
    input  logic [exu_pkg::XLEN-1:0]         pc_i,
    input  logic [exu_pkg::XLEN-1:0]         rs1_data_i,
    input  logic [exu_pkg::XLEN-1:0]         rs2_data_i,
    input  logic [exu_pkg::REG_ADDR_W-1:0]   rd_addr_i,
    // To memory stage
    output logic                             valid_o,
    output logic [exu_pkg::XLEN-1:0]         inst_o,
    output logic [exu_pkg::XLEN-1:0]         pc_o,
    output logic [exu_pkg::XLEN-1:0]         result_o,
    output logic [exu_pkg::XLEN-1:0]         rs2_data_o,
    output logic [exu_pkg::REG_ADDR_W-1:0]   rd_addr_o,
    output logic                             illegal_o
);

    import exu_pkg::*;

    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    logic            ex_valid;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    alu_op_e         alu_op;
    logic            ex_illegal;
    logic [XLEN-1:0] alu_result;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;

    assign id_ex_d = '{
        inst:     inst_i,
        pc:       pc_i,
        rs1_data: rs1_data_i,
        rs2_data: rs2_data_i,
        rd_addr:  rd_addr_i
    };

    pipe_stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .data_i   (id_ex_d),
        .valid_o  (ex_valid),
        .data_o   (id_ex_q)
    );

    operand_select i_operand_select (
        .inst_i     (id_ex_q.inst),
        .pc_i       (id_ex_q.pc),
        .rs1_data_i (id_ex_q.rs1_data),
        .rs2_data_i (id_ex_q.rs2_data),
        .op_a_o     (op_a),
        .op_b_o     (op_b)
    );

    alu_op_decoder i_alu_op_decoder (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .inst_i    (id_ex_q.inst),
        .alu_op_o  (alu_op),
        .illegal_o (ex_illegal)
    );

    int_alu i_int_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (alu_op),
        .result_o (alu_result)
    );

    assign ex_mem_d = '{
        inst:     id_ex_q.inst,
        pc:       id_ex_q.pc,
        result:   alu_result,
        rs2_data: id_ex_q.rs2_data,
        rd_addr:  id_ex_q.rd_addr,
        illegal:  ex_illegal
    };

    pipe_stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_valid),
        .data_i   (ex_mem_d),
        .valid_o  (valid_o),
        .data_o   (ex_mem_q)
    );

    assign inst_o     = ex_mem_q.inst;
    assign pc_o       = ex_mem_q.pc;
    assign result_o   = ex_mem_q.result;
    assign rs2_data_o = ex_mem_q.rs2_data;
    assign rd_addr_o  = ex_mem_q.rd_addr;
    // Held payload may carry a stale flag through a bubble
    assign illegal_o  = valid_o && ex_mem_q.illegal;

    // An illegal flag must trace back to a strobe two cycles earlier
    illegal_has_strobe_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        illegal_o |-> valid_o && $past(valid_i, 2)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release away from the clock edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;

    import exu_pkg::*;

    localparam int N_TESTS        = 500;
    localparam int CLK_PERIOD     = 20;
    localparam int TIMEOUT_CYCLES = N_TESTS * 2 + 40;

    logic                  clk;
    logic                  arst_n;
    logic                  valid;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  out_valid;
    logic [XLEN-1:0]       out_inst;
    logic [XLEN-1:0]       out_pc;
    logic [XLEN-1:0]       out_result;
    logic [XLEN-1:0]       out_rs2_data;
    logic [REG_ADDR_W-1:0] out_rd_addr;
    logic                  out_illegal;

    integer  seed;
    ex_mem_t expected_q[$];
    ex_mem_t exp_rec;
    int      sent_count;

    tb_clock i_tb_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    exec_unit i_exec_unit (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .valid_i    (valid),
        .inst_i     (inst),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_addr_i  (rd_addr),
        .valid_o    (out_valid),
        .inst_o     (out_inst),
        .pc_o       (out_pc),
        .result_o   (out_result),
        .rs2_data_o (out_rs2_data),
        .rd_addr_o  (out_rd_addr),
        .illegal_o  (out_illegal)
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [XLEN-1:0] ref_result(
        input logic [XLEN-1:0] word,
        input logic [XLEN-1:0] pc_val,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] rs2
    );
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] b;
        logic [4:0]      sh;
        logic            alt;
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_u = {word[31:12], 12'h000};
        b     = (word[6:0] == OPC_OP) ? rs2 : imm_i;
        sh    = b[4:0];
        alt   = (word[31:25] == 7'b0100000);
        case (word[6:0])
            OPC_LUI:   return imm_u;
            OPC_AUIPC: return pc_val + imm_u;
            OPC_LOAD:  return a + imm_i;
            OPC_STORE: return a + imm_s;
            OPC_OP, OPC_OP_IMM: begin
                case (word[14:12])
                    3'b000:  return (alt && word[6:0] == OPC_OP) ? a - b : a + b;
                    3'b001:  return a << sh;
                    // Differing sign bits decide a signed compare on their own
                    3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
                    3'b011:  return {31'd0, a < b};
                    3'b100:  return a ^ b;
                    3'b101:  return alt ? ((a >> sh) | (~({XLEN{1'b1}} >> sh) & {XLEN{a[31]}}))
                                        : (a >> sh);
                    3'b110:  return a | b;
                    default: return a & b;
                endcase
            end
            // Unsupported opcodes still add rs1 and rs2
            default:   return a + rs2;
        endcase
    endfunction

    task automatic drive_cycle(input logic strobe);
        logic [XLEN-1:0] word;
        logic [6:0]      opc;
        int unsigned     pick;
        ex_mem_t         rec;
        word = $random(seed);
        pick = $unsigned($random(seed)) % 7;
        case (pick)
            0:       opc = OPC_LUI;
            1:       opc = OPC_AUIPC;
            2:       opc = OPC_OP;
            3:       opc = OPC_OP_IMM;
            4:       opc = OPC_LOAD;
            5:       opc = OPC_STORE;
            default: begin
                opc = word[6:0];
                while (opc inside {OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE})
                    opc = opc + 7'd1;
            end
        endcase
        word[6:0] = opc;
        // Shifts and OP get a real funct7 so SUB and SRA/SRAI show up often
        if (opc == OPC_OP || (opc == OPC_OP_IMM && word[13:12] == 2'b01))
            word[31:25] = word[30] ? 7'b0100000 : 7'b0000000;
        valid    = strobe;
        inst     = word;
        pc       = $random(seed);
        rs1_data = $random(seed);
        rs2_data = $random(seed);
        rd_addr  = word[11:7];
        if (strobe) begin
            rec.inst     = word;
            rec.pc       = pc;
            rec.result   = ref_result(word, pc, rs1_data, rs2_data);
            rec.rs2_data = rs2_data;
            rec.rd_addr  = rd_addr;
            rec.illegal  = (pick >= 6);
            expected_q.push_back(rec);
            sent_count++;
        end
    endtask

    initial begin
        seed          = 32'h3c00;
        valid         = 1'b0;
        inst          = '0;
        pc            = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        rd_addr       = '0;
        sent_count    = 0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        reset_state_a: assert (!out_valid && !out_illegal && out_result == '0)
            else fail_run($sformatf("FAIL at %0t: outputs not cleared after reset", $time));
        while (sent_count < N_TESTS) begin
            @(posedge clk);
            #2;
            // About three cycles in four carry an instruction
            drive_cycle(($random(seed) & 3) != 0);
        end
        @(posedge clk);
        #2;
        valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        // Idle cycles so a stray valid_o still gets caught
        repeat (4) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

    // Compare each output strobe with the oldest outstanding instruction
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (expected_q.size() == 0) begin
                fail_run("The DUT raised valid_o with no instruction outstanding");
            end else begin
                exp_rec = expected_q.pop_front();
                result_a: assert (out_result == exp_rec.result)
                    else fail_run($sformatf("FAIL at %0t: result_o %h, expected %h (inst %h)",
                        $time, out_result, exp_rec.result, exp_rec.inst));
                inst_a: assert (out_inst == exp_rec.inst)
                    else fail_run($sformatf("FAIL at %0t: inst_o %h, expected %h",
                        $time, out_inst, exp_rec.inst));
                pc_a: assert (out_pc == exp_rec.pc)
                    else fail_run($sformatf("FAIL at %0t: pc_o %h, expected %h",
                        $time, out_pc, exp_rec.pc));
                rs2_a: assert (out_rs2_data == exp_rec.rs2_data)
                    else fail_run($sformatf("FAIL at %0t: rs2_data_o %h, expected %h",
                        $time, out_rs2_data, exp_rec.rs2_data));
                rd_a: assert (out_rd_addr == exp_rec.rd_addr)
                    else fail_run($sformatf("FAIL at %0t: rd_addr_o %0d, expected %0d",
                        $time, out_rd_addr, exp_rec.rd_addr));
                illegal_a: assert (out_illegal == exp_rec.illegal)
                    else fail_run($sformatf("FAIL at %0t: illegal_o %b, expected %b (inst %h)",
                        $time, out_illegal, exp_rec.illegal, exp_rec.inst));
            end
        end
    end

    strobe_latency_a: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid == $past(valid, 2)
    ) else fail_run($sformatf("FAIL at %0t: valid_o does not follow valid_i by two cycles",
        $time));

    illegal_with_valid_a: assert property (
        @(posedge clk) disable iff (!arst_n) !out_valid |-> !out_illegal
    ) else fail_run($sformatf("FAIL at %0t: illegal_o high without valid_o", $time));

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Timeout at %0t with %0d results still expected", $time,
            expected_q.size()));
    end

endmodule

`default_nettype wire

// File: exec_unit.f
source/exu_pkg.sv
source/pipe_stage_reg.sv
source/operand_select.sv
source/alu_op_decoder.sv
source/int_alu.sv
source/exec_unit.sv
bench/tb_clock.sv
bench/exec_unit_tb.sv

// File: Makefile
# Verilator build and run for the execute slice

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FLAGS     ?= --binary --timing --assert
BUILD_DIR ?= obj_dir
FILELIST  ?= exec_unit.f
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, FLAGS, BUILD_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
